// ==== compile.f ====
+incdir+common
common/mx_pkg.sv
verilog/mx_lane_dispatch.sv
mxint_accumulator/mxint_accumulator.sv
verilog/mx_result_collector.sv
verilog/mx_accum_array.sv
test/tb_mx_accum_array.sv

// ==== test/tb_mx_accum_array.sv ====
`default_nettype none

`include "mx_defs.svh"

module tb_mx_accum_array;

  timeunit 1ns;
  timeprecision 1ps;

  import mx_pkg::*;

  localparam int TOTAL_BLOCKS = 92;   // blocks sent over all tests
  localparam int CYCLE_LIMIT  = 40 * TOTAL_BLOCKS + 200;
  localparam int MANT_SPAN    = `MX_BLOCK_SIZE * `MX_ACC_W;
  localparam int ENTRY_W      = MANT_SPAN + `MX_EXP_W + `MX_LANE_W;

  logic  clk = 1'b0;
  logic  rst;
  mant_t in_mant [`MX_BLOCK_SIZE];
  exp_t  in_exp;
  lane_t in_lane;
  logic  in_valid;
  logic  in_ready;
  acc_t  res_mant [`MX_BLOCK_SIZE];
  exp_t  res_exp;
  lane_t res_lane;
  logic  res_valid;
  logic  res_ready;

  logic [31:0] lfsr_q = 32'h6a07be70;
  int errors = 0;
  int cycles = 0;

  logic [ENTRY_W-1:0] expect_q [$];   // {lane, exp, mantissas}

  // per-lane reference state
  acc_t model_mant [`MX_LANES][`MX_BLOCK_SIZE];
  exp_t model_exp  [`MX_LANES];
  int   model_cnt  [`MX_LANES];

  mant_t cur_mant [`MX_BLOCK_SIZE];   // block currently offered
  exp_t  cur_exp;
  lane_t cur_lane;

  logic  held = 1'b0;                 // result stalled at last edge
  acc_t  held_mant [`MX_BLOCK_SIZE];
  exp_t  held_exp;
  lane_t held_lane;

  mx_accum_array u_mx_accum_array (
    .clk       (clk),
    .rst       (rst),
    .in_mant   (in_mant),
    .in_exp    (in_exp),
    .in_lane   (in_lane),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .res_mant  (res_mant),
    .res_exp   (res_exp),
    .res_lane  (res_lane),
    .res_valid (res_valid),
    .res_ready (res_ready)
  );

  always #4 clk = ~clk;

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hd0000001) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  task automatic model_add();
    exp_t top;
    acc_t padded;
    logic [ENTRY_W-1:0] entry;
    if (model_cnt[cur_lane] == 0) begin
      model_exp[cur_lane] = cur_exp;
      for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
        model_mant[cur_lane][i] = acc_t'(int'(cur_mant[i]) * (2 ** `MX_FRAC_W));
      end
    end else begin
      top = (cur_exp > model_exp[cur_lane]) ? cur_exp : model_exp[cur_lane];
      for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
        padded = acc_t'(int'(cur_mant[i]) * (2 ** `MX_FRAC_W));
        model_mant[cur_lane][i] = (model_mant[cur_lane][i] >>> (top - model_exp[cur_lane]))
                                + (padded >>> (top - cur_exp));
      end
      model_exp[cur_lane] = top;
    end
    model_cnt[cur_lane]++;
    if (model_cnt[cur_lane] == `MX_DEPTH) begin
      entry = '0;
      for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
        entry[i*`MX_ACC_W +: `MX_ACC_W] = model_mant[cur_lane][i];
      end
      entry[MANT_SPAN +: `MX_EXP_W] = model_exp[cur_lane];
      entry[MANT_SPAN + `MX_EXP_W +: `MX_LANE_W] = cur_lane;
      expect_q.push_back(entry);
      model_cnt[cur_lane] = 0;
    end
  endtask

  // called at a falling edge
  task automatic drive_block(input lane_t lane, input exp_t e);
    cur_lane = lane;
    cur_exp  = e;
    for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
      cur_mant[i] = mant_t'(rand_bits(`MX_MANT_W));
      in_mant[i]  = cur_mant[i];
    end
    in_lane  = lane;
    in_exp   = e;
    in_valid = 1'b1;
  endtask

  task automatic finish_block();
    do begin
      @(posedge clk);
    end while (!in_ready);
    model_add();
    @(negedge clk);
    in_valid = 1'b0;   // next block may raise it again at once
  endtask

  task automatic send_block(input lane_t lane, input exp_t e);
    drive_block(lane, e);
    finish_block();
  endtask

  task automatic drain_results();
    int waited;
    waited = 0;
    while (expect_q.size() != 0 && waited < 100) begin
      @(negedge clk);
      waited++;
    end
    if (expect_q.size() != 0) begin
      $display("%0d expected results never arrived", expect_q.size());
      errors += expect_q.size();
      expect_q.delete();
    end
  endtask

  // match against the oldest pending sum of the same lane
  task automatic check_result();
    int idx;
    logic [ENTRY_W-1:0] want;
    acc_t want_m;
    exp_t want_e;
    idx = -1;
    for (int k = 0; k < expect_q.size(); k++) begin
      if (idx < 0 && expect_q[k][MANT_SPAN + `MX_EXP_W +: `MX_LANE_W] == res_lane) begin
        idx = k;
      end
    end
    if (idx < 0) begin
      if (expect_q.size() == 0) begin
        $display("result from lane %0d arrived with no sum pending", res_lane);
      end else begin
        $display("Fail res_lane: got %h expected %h", res_lane,
                 expect_q[0][MANT_SPAN + `MX_EXP_W +: `MX_LANE_W]);
      end
      errors++;
    end else begin
      want = expect_q[idx];
      expect_q.delete(idx);
      want_e = want[MANT_SPAN +: `MX_EXP_W];
      if (res_exp != want_e) begin
        $display("Fail res_exp lane %0d: got %h expected %h", res_lane, res_exp, want_e);
        errors++;
      end
      for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
        want_m = want[i*`MX_ACC_W +: `MX_ACC_W];
        if (res_mant[i] != want_m) begin
          $display("Fail res_mant[%0d] lane %0d: got %h expected %h",
                   i, res_lane, res_mant[i], want_m);
          errors++;
        end
      end
    end
  endtask

  always @(posedge clk) begin : monitor
    logic changed;
    if (!rst) begin
      if (held) begin
        changed = !res_valid || res_exp != held_exp || res_lane != held_lane;
        for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
          changed = changed || (res_mant[i] != held_mant[i]);
        end
        if (changed) begin
          $display("result changed while res_ready was low");
          errors++;
        end
      end
      if (res_valid && res_ready) begin
        check_result();
      end
      held      = res_valid && !res_ready;
      held_mant = res_mant;
      held_exp  = res_exp;
      held_lane = res_lane;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles", cycles);
      errors++;
      $display("errors: %0d", errors);
      $display("tests failed");
      $finish;
    end
  end

  task automatic test_reset_state();
    if (res_valid !== 1'b0) begin
      $display("Fail res_valid: got %h expected 0", res_valid);
      errors++;
    end
    if (in_ready !== 1'b1) begin
      $display("Fail in_ready: got %h expected 1", in_ready);
      errors++;
    end
    repeat (12) begin
      @(posedge clk);
      if (res_valid) begin
        $display("Fail res_valid: got %h expected 0", res_valid);
        errors++;
      end
    end
    @(negedge clk);
  endtask

  task automatic test_equal_exp();
    for (int n = 0; n < `MX_DEPTH; n++) begin
      send_block(lane_t'(2), exp_t'(9));
    end
    drain_results();
  endtask

  task automatic test_mixed_exp();
    for (int n = 0; n < 2 * `MX_DEPTH; n++) begin
      send_block(lane_t'(1), exp_t'(rand_bits(`MX_EXP_W)));
    end
    drain_results();
  endtask

  task automatic test_interleaved();
    int    left [`MX_LANES];
    lane_t pick;
    for (int l = 0; l < `MX_LANES; l++) begin
      left[l] = 3 * `MX_DEPTH;
    end
    for (int n = 0; n < 3 * `MX_DEPTH * `MX_LANES; n++) begin
      pick = lane_t'(rand_bits(`MX_LANE_W));
      while (left[pick] == 0) begin
        pick = pick + 1'b1;   // wraps past the last lane
      end
      left[pick]--;
      send_block(pick, exp_t'(rand_bits(`MX_EXP_W)));
    end
    drain_results();
  endtask

  task automatic test_backpressure();
    res_ready = 1'b0;
    for (int l = 0; l < `MX_LANES; l++) begin
      for (int n = 0; n < `MX_DEPTH; n++) begin
        send_block(lane_t'(l), exp_t'(rand_bits(`MX_EXP_W)));
      end
    end
    repeat (4) @(negedge clk);
    if (!res_valid) begin
      $display("Fail res_valid: got %h expected 1", res_valid);
      errors++;
    end
    // lane 1 holds a finished sum, so this block must stall
    drive_block(lane_t'(1), exp_t'(rand_bits(`MX_EXP_W)));
    repeat (6) begin
      @(posedge clk);
      if (in_ready) begin
        $display("Fail in_ready: got %h expected 0", in_ready);
        errors++;
      end
    end
    @(negedge clk);
    res_ready = 1'b1;
    finish_block();
    for (int n = 1; n < `MX_DEPTH; n++) begin
      send_block(lane_t'(1), exp_t'(rand_bits(`MX_EXP_W)));
    end
    drain_results();
  endtask

  task automatic test_back_to_back();
    for (int n = 0; n < 3 * `MX_DEPTH; n++) begin
      send_block(lane_t'(3), exp_t'(rand_bits(`MX_EXP_W)));
    end
    drain_results();
  endtask

  initial begin
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_lane   = '0;
    in_exp    = '0;
    res_ready = 1'b1;
    for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
      in_mant[i] = '0;
    end
    repeat (16) @(negedge clk);
    rst = 1'b0;

    test_reset_state();
    test_equal_exp();
    test_mixed_exp();
    test_interleaved();
    test_backpressure();
    test_back_to_back();

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/mx_accum_array.sv ====
`default_nettype none

`include "mx_defs.svh"

module mx_accum_array (
  input  wire logic          clk,
  input  wire logic          rst,

  input  wire mx_pkg::mant_t in_mant [`MX_BLOCK_SIZE],
  input  wire mx_pkg::exp_t  in_exp,
  input  wire mx_pkg::lane_t in_lane,
  input  wire logic          in_valid,
  output logic               in_ready,

  output mx_pkg::acc_t       res_mant [`MX_BLOCK_SIZE],
  output mx_pkg::exp_t       res_exp,
  output mx_pkg::lane_t      res_lane,
  output logic               res_valid,
  input  wire logic          res_ready
);

  import mx_pkg::*;

  logic [`MX_LANES-1:0] lane_valid;
  logic [`MX_LANES-1:0] lane_ready;

  acc_t                 lane_mant [`MX_LANES][`MX_BLOCK_SIZE];
  exp_t                 lane_exp  [`MX_LANES];
  logic [`MX_LANES-1:0] lane_sum_valid;
  logic [`MX_LANES-1:0] lane_sum_ready;

  mx_lane_dispatch u_dispatch (
    .in_lane    (in_lane),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .lane_valid (lane_valid),
    .lane_ready (lane_ready)
  );

  // block payload goes to every lane, valid picks the one that takes it
  for (genvar g = 0; g < `MX_LANES; g++) begin : g_lane
    mxint_accumulator u_lane (
      .clk       (clk),
      .rst       (rst),
      .blk_mant  (in_mant),
      .blk_exp   (in_exp),
      .blk_valid (lane_valid[g]),
      .blk_ready (lane_ready[g]),
      .sum_mant  (lane_mant[g]),
      .sum_exp   (lane_exp[g]),
      .sum_valid (lane_sum_valid[g]),
      .sum_ready (lane_sum_ready[g])
    );
  end

  mx_result_collector u_collect (
    .clk       (clk),
    .rst       (rst),
    .sum_mant  (lane_mant),
    .sum_exp   (lane_exp),
    .sum_valid (lane_sum_valid),
    .sum_ready (lane_sum_ready),
    .res_mant  (res_mant),
    .res_exp   (res_exp),
    .res_lane  (res_lane),
    .res_valid (res_valid),
    .res_ready (res_ready)
  );

endmodule

`default_nettype wire

// ==== verilog/mx_result_collector.sv ====
`default_nettype none

`include "mx_defs.svh"

module mx_result_collector (
  input  wire logic                 clk,
  input  wire logic                 rst,

  input  wire mx_pkg::acc_t         sum_mant [`MX_LANES][`MX_BLOCK_SIZE],
  input  wire mx_pkg::exp_t         sum_exp  [`MX_LANES],
  input  wire logic [`MX_LANES-1:0] sum_valid,
  output logic [`MX_LANES-1:0]      sum_ready,

  output mx_pkg::acc_t              res_mant [`MX_BLOCK_SIZE],
  output mx_pkg::exp_t              res_exp,
  output mx_pkg::lane_t             res_lane,
  output logic                      res_valid,
  input  wire logic                 res_ready
);

  import mx_pkg::*;

  lane_t last_q;     // lane granted most recently
  lane_t gnt_lane;
  logic  found;
  logic  take;

  // round-robin search, starting just after the last grant
  always_comb begin
    int idx;
    found    = 1'b0;
    gnt_lane = last_q;
    for (int k = 1; k <= `MX_LANES; k++) begin
      idx = (int'(last_q) + k) % `MX_LANES;
      if (!found && sum_valid[idx]) begin
        found    = 1'b1;
        gnt_lane = lane_t'(idx);
      end
    end
  end

  // output register free or draining this cycle
  assign take = found && (!res_valid || res_ready);

  always_comb begin
    sum_ready = '0;
    if (take) begin
      sum_ready[gnt_lane] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
      last_q    <= lane_t'(`MX_LANES - 1);   // lane 0 gets first pick
    end else if (take) begin
      res_valid <= 1'b1;
      last_q    <= gnt_lane;
    end else if (res_ready) begin
      res_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      res_mant <= sum_mant[gnt_lane];
      res_exp  <= sum_exp[gnt_lane];
      res_lane <= gnt_lane;
    end
  end

endmodule

`default_nettype wire

// ==== mxint_accumulator/mxint_accumulator.sv ====
`default_nettype none

`include "mx_defs.svh"

module mxint_accumulator (
  input  wire logic          clk,
  input  wire logic          rst,

  input  wire mx_pkg::mant_t blk_mant [`MX_BLOCK_SIZE],
  input  wire mx_pkg::exp_t  blk_exp,
  input  wire logic          blk_valid,
  output logic               blk_ready,

  output mx_pkg::acc_t       sum_mant [`MX_BLOCK_SIZE],
  output mx_pkg::exp_t       sum_exp,
  output logic               sum_valid,
  input  wire logic          sum_ready
);

  import mx_pkg::*;

  logic [`MX_CNT_W-1:0] cnt_q;    // blocks taken into the current sum

  logic take;                     // block accepted this cycle
  logic handoff;                  // finished sum leaves this cycle
  logic fresh;                    // incoming block starts a new sum

  exp_t exp_new;
  exp_t acc_shift;
  exp_t in_shift;

  acc_t padded   [`MX_BLOCK_SIZE];
  acc_t acc_next [`MX_BLOCK_SIZE];

  assign sum_valid = (cnt_q == `MX_CNT_W'(`MX_DEPTH));
  assign blk_ready = !sum_valid || sum_ready;   // stall only while a sum waits

  assign handoff = sum_valid && sum_ready;
  assign take    = blk_valid && blk_ready;
  assign fresh   = (cnt_q == '0) || handoff;

  // shared exponent after this block
  always_comb begin
    if (fresh) begin
      exp_new = blk_exp;
    end else if (blk_exp > sum_exp) begin
      exp_new = blk_exp;
    end else begin
      exp_new = sum_exp;
    end
  end

  // both sides realign to the larger exponent
  assign acc_shift = exp_new - sum_exp;
  assign in_shift  = exp_new - blk_exp;

  always_comb begin
    for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
      // sign extend, then place the fraction bits below
      padded[i] = acc_t'(blk_mant[i]) <<< `MX_FRAC_W;

      if (fresh) begin
        acc_next[i] = padded[i];
      end else begin
        // arithmetic shifts truncate toward minus infinity
        acc_next[i] = (sum_mant[i] >>> acc_shift) + (padded[i] >>> in_shift);
      end
    end
  end

  // block counter
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q <= '0;
    end else if (take) begin
      if (fresh) begin
        cnt_q <= `MX_CNT_W'(1);         // restart on the handoff block
      end else begin
        cnt_q <= cnt_q + `MX_CNT_W'(1);
      end
    end else if (handoff) begin
      cnt_q <= '0;                      // drained with nothing behind it
    end
  end

  // running sum, only meaningful while cnt_q is nonzero
  always_ff @(posedge clk) begin
    if (take) begin
      sum_exp <= exp_new;
      for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
        sum_mant[i] <= acc_next[i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mx_lane_dispatch.sv ====
`default_nettype none

`include "mx_defs.svh"

module mx_lane_dispatch (
  input  wire mx_pkg::lane_t        in_lane,
  input  wire logic                 in_valid,
  output logic                      in_ready,
  output logic [`MX_LANES-1:0]      lane_valid,
  input  wire logic [`MX_LANES-1:0] lane_ready
);

  import mx_pkg::*;

  // one-hot valid toward the addressed lane only
  always_comb begin
    for (int l = 0; l < `MX_LANES; l++) begin
      lane_valid[l] = in_valid && (in_lane == lane_t'(l));
    end
  end

  // a full lane stalls only the blocks sent to it
  assign in_ready = lane_ready[in_lane];

endmodule

`default_nettype wire

// ==== common/mx_pkg.sv ====
`default_nettype none

`include "mx_defs.svh"

package mx_pkg;

  // one input mantissa, two's complement
  typedef logic signed [`MX_MANT_W-1:0] mant_t;

  // accumulated mantissa, holds `MX_FRAC_W fraction bits
  typedef logic signed [`MX_ACC_W-1:0] acc_t;

  // shared block exponent, raw and unbiased
  typedef logic [`MX_EXP_W-1:0] exp_t;

  // accumulator lane index
  typedef logic [`MX_LANE_W-1:0] lane_t;

endpackage

`default_nettype wire

// ==== common/mx_defs.svh ====
`ifndef MX_DEFS_SVH
`define MX_DEFS_SVH

// block shape
`define MX_BLOCK_SIZE 4
`define MX_MANT_W 8
`define MX_EXP_W 4

// fraction bits kept below each input mantissa
`define MX_FRAC_W 8

// blocks summed into one result
`define MX_DEPTH 4
`define MX_CNT_W 3

// two guard bits cover DEPTH sums of padded values
`define MX_ACC_W (`MX_MANT_W + `MX_FRAC_W + 2)

`define MX_LANES 4
`define MX_LANE_W 2

`endif
